// File: common/icache_pkg.sv
package icache_pkg;

  // address widths
  parameter int vaddr_width_gp       = 32;
  parameter int paddr_width_gp       = 34;
  parameter int page_offset_width_gp = 12;
  parameter int ptag_width_gp        = paddr_width_gp - page_offset_width_gp;
  parameter int instr_width_gp       = 32;

  // ways and banks share one count
  parameter int assoc_gp       = 4;
  parameter int sets_gp        = 64;
  parameter int block_width_gp = 512;
  parameter int bank_width_gp  = block_width_gp / assoc_gp;

  // field widths for the default geometry
  parameter int way_id_width_gp      = $clog2(assoc_gp);
  parameter int index_width_gp       = $clog2(sets_gp);
  parameter int word_offset_width_gp = $clog2(assoc_gp);
  parameter int byte_offset_width_gp = $clog2(bank_width_gp / 8);
  parameter int lru_width_gp         = assoc_gp - 1;

  // tag fill operations
  typedef enum logic [1:0] {
    set_clear  = 2'b00,
    invalidate = 2'b01,
    set_tag    = 2'b10
  } tag_op_e;

endpackage

// File: src/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup
  import icache_pkg::*;
#(
  parameter int assoc_p = assoc_gp,
  parameter int sets_p  = sets_gp,
  localparam int way_id_width_lp = $clog2(assoc_p),
  localparam int index_width_lp  = $clog2(sets_p)
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       tl_we_i,
  input  logic [vaddr_width_gp-1:0]  vaddr_i,
  input  logic [ptag_width_gp-1:0]   ptag_i,
  input  logic                       tag_fill_v_i,
  input  tag_op_e                    tag_fill_op_i,
  input  logic [index_width_lp-1:0]  tag_fill_index_i,
  input  logic [way_id_width_lp-1:0] tag_fill_way_i,
  input  logic [ptag_width_gp-1:0]   tag_fill_tag_i,
  output logic                       tag_fill_yumi_o,
  output logic                       v_tl_o,
  output logic [vaddr_width_gp-1:0]  vaddr_tl_o,
  output logic [assoc_p-1:0]         hit_tl_o,
  output logic [assoc_p-1:0]         way_v_tl_o
);

  localparam int block_offset_width_lp = $clog2(block_width_gp / 8);
  // valid bit sits above the tag
  localparam int entry_width_lp = ptag_width_gp + 1;

  logic [index_width_lp-1:0] vaddr_index;
  logic [assoc_p-1:0] way_dec;
  logic [assoc_p-1:0][entry_width_lp-1:0] tag_mem [sets_p];
  logic [assoc_p-1:0][entry_width_lp-1:0] tag_rd_r;
  logic [assoc_p-1:0][entry_width_lp-1:0] w_data;
  logic [assoc_p-1:0][entry_width_lp-1:0] w_mask;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_o <= 1'b0;
    end else begin
      v_tl_o <= tl_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we_i) begin
      vaddr_tl_o <= vaddr_i;
    end
  end

  // TL read owns the port
  assign tag_fill_yumi_o = tag_fill_v_i & ~tl_we_i;
  assign vaddr_index = vaddr_i[block_offset_width_lp +: index_width_lp];

  always_comb begin
    way_dec = '0;
    way_dec[tag_fill_way_i] = 1'b1;
    w_data = '0;
    w_mask = '0;
    for (int i = 0; i < assoc_p; i++) begin
      case (tag_fill_op_i)
        set_clear: w_mask[i] = '1;
        invalidate: w_mask[i][ptag_width_gp] = way_dec[i];
        set_tag: begin
          w_data[i] = {1'b1, tag_fill_tag_i};
          w_mask[i] = {entry_width_lp{way_dec[i]}};
        end
        default: w_mask[i] = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we_i) begin
      tag_rd_r <= tag_mem[vaddr_index];
    end else if (tag_fill_yumi_o) begin
      tag_mem[tag_fill_index_i] <= (tag_mem[tag_fill_index_i] & ~w_mask)
                                 | (w_data & w_mask);
    end
  end

  for (genvar i = 0; i < assoc_p; i++) begin : g_cmp
    assign way_v_tl_o[i] = tag_rd_r[i][ptag_width_gp];
    assign hit_tl_o[i] = way_v_tl_o[i] & (tag_rd_r[i][ptag_width_gp-1:0] == ptag_i);
  end

  // the fill agent never loads one tag into two ways of a set
  assert property (@(posedge clk_i) disable iff (reset_i) v_tl_o |-> $onehot0(hit_tl_o));

endmodule

// File: src/data_banks.sv
`timescale 1ns/1ps

module data_banks
  import icache_pkg::*;
#(
  parameter int assoc_p = assoc_gp,
  parameter int sets_p  = sets_gp,
  localparam int way_id_width_lp = $clog2(assoc_p),
  localparam int index_width_lp  = $clog2(sets_p),
  localparam int bank_width_lp   = block_width_gp / assoc_p
) (
  input  logic                                  clk_i,
  input  logic                                  tl_we_i,
  input  logic [vaddr_width_gp-1:0]             vaddr_i,
  input  logic                                  data_fill_v_i,
  input  logic [index_width_lp-1:0]             data_fill_index_i,
  input  logic [way_id_width_lp-1:0]            data_fill_way_i,
  input  logic [block_width_gp-1:0]             data_fill_block_i,
  output logic                                  data_fill_yumi_o,
  output logic [assoc_p-1:0][bank_width_lp-1:0] bank_data_o
);

  localparam int byte_offset_width_lp = $clog2(bank_width_lp / 8);
  localparam int addr_width_lp = index_width_lp + way_id_width_lp;

  logic [index_width_lp-1:0] vaddr_index;
  logic [way_id_width_lp-1:0] vaddr_offset;
  // stage s of the butterfly rotates by 2**s banks
  logic [way_id_width_lp:0][assoc_p-1:0][bank_width_lp-1:0] rot;

  assign data_fill_yumi_o = data_fill_v_i & ~tl_we_i;
  assign vaddr_offset = vaddr_i[byte_offset_width_lp +: way_id_width_lp];
  assign vaddr_index = vaddr_i[byte_offset_width_lp + way_id_width_lp +: index_width_lp];
  assign rot[0] = data_fill_block_i;

  for (genvar s = 0; s < way_id_width_lp; s++) begin : g_stage
    for (genvar i = 0; i < assoc_p; i++) begin : g_word
      assign rot[s+1][i] = data_fill_way_i[s] ? rot[s][(i + assoc_p - (1 << s)) % assoc_p]
                                              : rot[s][i];
    end
  end

  for (genvar b = 0; b < assoc_p; b++) begin : g_bank
    logic [bank_width_lp-1:0] mem [sets_p*assoc_p];
    logic [bank_width_lp-1:0] rd_r;
    logic [way_id_width_lp-1:0] fill_offset;
    logic [addr_width_lp-1:0] addr;

    // block word this bank takes for the filled way
    assign fill_offset = way_id_width_lp'(b) - data_fill_way_i;
    assign addr = tl_we_i ? {vaddr_index, vaddr_offset}
                          : {data_fill_index_i, fill_offset};

    always_ff @(posedge clk_i) begin
      if (tl_we_i) begin
        rd_r <= mem[addr];
      end else if (data_fill_yumi_o) begin
        mem[addr] <= rot[way_id_width_lp][b];
      end
    end

    assign bank_data_o[b] = rd_r;
  end

endmodule

// File: src/lru_tracker.sv
`timescale 1ns/1ps

module lru_tracker
  import icache_pkg::*;
#(
  parameter int assoc_p = assoc_gp,
  parameter int sets_p  = sets_gp,
  localparam int way_id_width_lp = $clog2(assoc_p),
  localparam int index_width_lp  = $clog2(sets_p)
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       v_tv_i,
  input  logic                       miss_tv_i,
  input  logic [index_width_lp-1:0]  addr_index_tv_i,
  input  logic [assoc_p-1:0]         hit_tv_i,
  input  logic [assoc_p-1:0]         way_v_tv_i,
  input  logic                       cache_req_v_i,
  output logic [way_id_width_lp-1:0] repl_way_o,
  output logic                       repl_way_v_o
);

  localparam int lru_width_lp = assoc_p - 1;

  logic [lru_width_lp-1:0] lru_mem [sets_p];
  logic [lru_width_lp-1:0] lru_rd;
  logic [lru_width_lp-1:0] lru_next;
  logic [way_id_width_lp-1:0] hit_way;
  logic [way_id_width_lp-1:0] lru_way;
  logic [way_id_width_lp-1:0] invalid_way;
  logic invalid_exist;
  logic invalid_exist_r;
  logic [way_id_width_lp-1:0] invalid_way_r;
  logic [way_id_width_lp-1:0] lru_way_r;

  assign lru_rd = lru_mem[addr_index_tv_i];

  always_comb begin
    hit_way = '0;
    invalid_exist = 1'b0;
    invalid_way = '0;
    for (int i = assoc_p - 1; i >= 0; i--) begin
      if (hit_tv_i[i]) begin
        hit_way = way_id_width_lp'(i);
      end
      // lowest invalid way ends up last
      if (!way_v_tv_i[i]) begin
        invalid_exist = 1'b1;
        invalid_way = way_id_width_lp'(i);
      end
    end
  end

  // heap order where node n has children 2n+1 and 2n+2
  always_comb begin
    int hit_node;
    int lru_node;
    hit_node = 0;
    lru_node = 0;
    lru_next = lru_rd;
    lru_way = '0;
    for (int l = way_id_width_lp - 1; l >= 0; l--) begin
      // point away from the way just hit
      lru_next[hit_node] = ~hit_way[l];
      hit_node = 2 * hit_node + 1 + int'(hit_way[l]);
      lru_way[l] = lru_rd[lru_node];
      lru_node = 2 * lru_node + 1 + int'(lru_rd[lru_node]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        lru_mem[s] <= '0;
      end
    end else if (v_tv_i && !miss_tv_i) begin
      lru_mem[addr_index_tv_i] <= lru_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      repl_way_v_o <= 1'b0;
    end else begin
      repl_way_v_o <= cache_req_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_i) begin
      invalid_exist_r <= invalid_exist;
      invalid_way_r <= invalid_way;
      lru_way_r <= lru_way;
    end
  end

  // an empty way beats the tree
  assign repl_way_o = invalid_exist_r ? invalid_way_r : lru_way_r;

endmodule

// File: src/tv_stage.sv
`timescale 1ns/1ps

module tv_stage
  import icache_pkg::*;
#(
  parameter int assoc_p = assoc_gp,
  parameter int sets_p  = sets_gp,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int bank_width_lp  = block_width_gp / assoc_p
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  v_tl_i,
  input  logic                                  ptag_v_i,
  input  logic [vaddr_width_gp-1:0]             vaddr_tl_i,
  input  logic [ptag_width_gp-1:0]              ptag_i,
  input  logic [assoc_p-1:0]                    hit_tl_i,
  input  logic [assoc_p-1:0]                    way_v_tl_i,
  input  logic [assoc_p-1:0][bank_width_lp-1:0] bank_data_i,
  input  logic                                  cache_req_ready_i,
  output logic [instr_width_gp-1:0]             instr_o,
  output logic                                  instr_v_o,
  output logic                                  miss_tv_o,
  output logic [paddr_width_gp-1:0]             cache_req_o,
  output logic                                  cache_req_v_o,
  output logic [index_width_lp-1:0]             addr_index_tv_o,
  output logic [assoc_p-1:0]                    hit_tv_o,
  output logic [assoc_p-1:0]                    way_v_tv_o
);

  localparam int way_id_width_lp = $clog2(assoc_p);
  localparam int byte_offset_width_lp = $clog2(bank_width_lp / 8);
  localparam int instr_sel_width_lp = byte_offset_width_lp - 2;

  logic tv_we;
  logic v_tv_r;
  logic [paddr_width_gp-1:0] addr_tv_r;
  logic [assoc_p-1:0][bank_width_lp-1:0] data_tv_r;
  logic [way_id_width_lp-1:0] hit_way;
  logic [way_id_width_lp-1:0] word_offset;
  logic [way_id_width_lp-1:0] bank_sel;
  logic [instr_sel_width_lp-1:0] instr_sel;
  logic [bank_width_lp-1:0] bank_word;

  // an access without a ptag is dropped
  assign tv_we = v_tl_i & ptag_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      addr_tv_r <= {ptag_i, vaddr_tl_i[page_offset_width_gp-1:0]};
      hit_tv_o <= hit_tl_i;
      way_v_tv_o <= way_v_tl_i;
      data_tv_r <= bank_data_i;
    end
  end

  always_comb begin
    hit_way = '0;
    for (int i = 0; i < assoc_p; i++) begin
      if (hit_tv_o[i]) begin
        hit_way = way_id_width_lp'(i);
      end
    end
  end

  assign word_offset = addr_tv_r[byte_offset_width_lp +: way_id_width_lp];
  assign instr_sel = addr_tv_r[2 +: instr_sel_width_lp];

  // word w of way k was stored in bank (w + k) mod assoc
  assign bank_sel = hit_way + word_offset;
  assign bank_word = data_tv_r[bank_sel];
  assign instr_o = bank_word[instr_sel*instr_width_gp +: instr_width_gp];

  assign miss_tv_o = v_tv_r & ~|hit_tv_o;
  assign instr_v_o = v_tv_r & |hit_tv_o;
  assign cache_req_o = addr_tv_r;
  assign cache_req_v_o = miss_tv_o & cache_req_ready_i;
  assign addr_index_tv_o = addr_tv_r[byte_offset_width_lp + way_id_width_lp +: index_width_lp];

  // ptag only follows an access sitting in TL
  assert property (@(posedge clk_i) disable iff (reset_i) ptag_v_i |-> v_tl_i);

endmodule

// File: src/icache.sv
`timescale 1ns/1ps

module icache
  import icache_pkg::*;
#(
  parameter int assoc_p = assoc_gp,
  parameter int sets_p  = sets_gp,
  localparam int way_id_width_lp = $clog2(assoc_p),
  localparam int index_width_lp  = $clog2(sets_p)
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [vaddr_width_gp-1:0]  vaddr_i,
  input  logic                       vaddr_v_i,
  output logic                       vaddr_ready_o,
  input  logic [ptag_width_gp-1:0]   ptag_i,
  input  logic                       ptag_v_i,
  output logic [instr_width_gp-1:0]  instr_o,
  output logic                       instr_v_o,
  output logic                       miss_o,
  output logic [paddr_width_gp-1:0]  cache_req_o,
  output logic                       cache_req_v_o,
  input  logic                       cache_req_ready_i,
  output logic [way_id_width_lp-1:0] repl_way_o,
  output logic                       repl_way_v_o,
  input  logic                       cache_req_complete_i,
  input  logic                       tag_fill_v_i,
  input  tag_op_e                    tag_fill_op_i,
  input  logic [index_width_lp-1:0]  tag_fill_index_i,
  input  logic [way_id_width_lp-1:0] tag_fill_way_i,
  input  logic [ptag_width_gp-1:0]   tag_fill_tag_i,
  output logic                       tag_fill_yumi_o,
  input  logic                       data_fill_v_i,
  input  logic [index_width_lp-1:0]  data_fill_index_i,
  input  logic [way_id_width_lp-1:0] data_fill_way_i,
  input  logic [block_width_gp-1:0]  data_fill_block_i,
  output logic                       data_fill_yumi_o
);

  localparam int bank_width_lp = block_width_gp / assoc_p;

  logic tl_we;
  logic miss_r;
  logic v_tl;
  logic v_tv;
  logic miss_tv;
  logic [vaddr_width_gp-1:0] vaddr_tl;
  logic [assoc_p-1:0] hit_tl;
  logic [assoc_p-1:0] way_v_tl;
  logic [assoc_p-1:0] hit_tv;
  logic [assoc_p-1:0] way_v_tv;
  logic [assoc_p-1:0][bank_width_lp-1:0] bank_data;
  logic [index_width_lp-1:0] addr_index_tv;

  // no new access while a miss is pending or being raised
  assign vaddr_ready_o = cache_req_ready_i & ~miss_r & ~cache_req_v_o;
  assign tl_we = vaddr_v_i & vaddr_ready_o;

  // a live TV access either hits or misses
  assign v_tv = instr_v_o | miss_tv;

  // miss tracker
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_r <= 1'b0;
    end else if (cache_req_v_o) begin
      miss_r <= 1'b1;
    end else if (cache_req_complete_i) begin
      miss_r <= 1'b0;
    end
  end

  assign miss_o = miss_r;

  tag_lookup #(.assoc_p(assoc_p), .sets_p(sets_p)) i_tag_lookup (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .tl_we_i          (tl_we),
    .vaddr_i          (vaddr_i),
    .ptag_i           (ptag_i),
    .tag_fill_v_i     (tag_fill_v_i),
    .tag_fill_op_i    (tag_fill_op_i),
    .tag_fill_index_i (tag_fill_index_i),
    .tag_fill_way_i   (tag_fill_way_i),
    .tag_fill_tag_i   (tag_fill_tag_i),
    .tag_fill_yumi_o  (tag_fill_yumi_o),
    .v_tl_o           (v_tl),
    .vaddr_tl_o       (vaddr_tl),
    .hit_tl_o         (hit_tl),
    .way_v_tl_o       (way_v_tl)
  );

  data_banks #(.assoc_p(assoc_p), .sets_p(sets_p)) i_data_banks (
    .clk_i             (clk_i),
    .tl_we_i           (tl_we),
    .vaddr_i           (vaddr_i),
    .data_fill_v_i     (data_fill_v_i),
    .data_fill_index_i (data_fill_index_i),
    .data_fill_way_i   (data_fill_way_i),
    .data_fill_block_i (data_fill_block_i),
    .data_fill_yumi_o  (data_fill_yumi_o),
    .bank_data_o       (bank_data)
  );

  tv_stage #(.assoc_p(assoc_p), .sets_p(sets_p)) i_tv_stage (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .v_tl_i            (v_tl),
    .ptag_v_i          (ptag_v_i),
    .vaddr_tl_i        (vaddr_tl),
    .ptag_i            (ptag_i),
    .hit_tl_i          (hit_tl),
    .way_v_tl_i        (way_v_tl),
    .bank_data_i       (bank_data),
    .cache_req_ready_i (cache_req_ready_i),
    .instr_o           (instr_o),
    .instr_v_o         (instr_v_o),
    .miss_tv_o         (miss_tv),
    .cache_req_o       (cache_req_o),
    .cache_req_v_o     (cache_req_v_o),
    .addr_index_tv_o   (addr_index_tv),
    .hit_tv_o          (hit_tv),
    .way_v_tv_o        (way_v_tv)
  );

  lru_tracker #(.assoc_p(assoc_p), .sets_p(sets_p)) i_lru_tracker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .v_tv_i          (v_tv),
    .miss_tv_i       (miss_tv),
    .addr_index_tv_i (addr_index_tv),
    .hit_tv_i        (hit_tv),
    .way_v_tv_i      (way_v_tv),
    .cache_req_v_i   (cache_req_v_o),
    .repl_way_o      (repl_way_o),
    .repl_way_v_o    (repl_way_v_o)
  );

  // the fill agent only completes a fill that was requested
  assert property (@(posedge clk_i) disable iff (reset_i) cache_req_complete_i |-> miss_o);

endmodule

// File: test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam int strobe_wait_lp = 8;
  localparam int slot_width_lp = byte_offset_width_gp - 2;

  typedef enum logic [2:0] {
    op_clear, op_tag, op_inval, op_block, op_acc, op_sweep, op_new, op_done
  } op_e;

  // exp_hit is the expected outcome of an access row
  typedef struct packed {
    op_e  op;
    int   idx;
    int   way;
    logic exp_hit;
  } row_t;

  logic clk_i;
  logic reset_i;
  logic [vaddr_width_gp-1:0] vaddr_i;
  logic vaddr_v_i;
  logic vaddr_ready_o;
  logic [ptag_width_gp-1:0] ptag_i;
  logic ptag_v_i;
  logic [instr_width_gp-1:0] instr_o;
  logic instr_v_o;
  logic miss_o;
  logic [paddr_width_gp-1:0] cache_req_o;
  logic cache_req_v_o;
  logic cache_req_ready_i;
  logic [way_id_width_gp-1:0] repl_way_o;
  logic repl_way_v_o;
  logic cache_req_complete_i;
  logic tag_fill_v_i;
  tag_op_e tag_fill_op_i;
  logic [index_width_gp-1:0] tag_fill_index_i;
  logic [way_id_width_gp-1:0] tag_fill_way_i;
  logic [ptag_width_gp-1:0] tag_fill_tag_i;
  logic tag_fill_yumi_o;
  logic data_fill_v_i;
  logic [index_width_gp-1:0] data_fill_index_i;
  logic [way_id_width_gp-1:0] data_fill_way_i;
  logic [block_width_gp-1:0] data_fill_block_i;
  logic data_fill_yumi_o;

  row_t stim_q[$];
  logic table_built = 1'b0;
  logic [31:0] lcg_state;
  logic miss_pending;

  // reference model of the cache contents
  logic                      valid_m [sets_gp][assoc_gp];
  logic [ptag_width_gp-1:0]  tag_m   [sets_gp][assoc_gp];
  logic [block_width_gp-1:0] block_m [sets_gp][assoc_gp];
  logic [lru_width_gp-1:0]   plru_m  [sets_gp];

  icache #(.assoc_p(assoc_gp), .sets_p(sets_gp)) i_icache (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_instr(logic [instr_width_gp-1:0] got, logic [instr_width_gp-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch instr_o: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_req_addr(logic [paddr_width_gp-1:0] got,
                                logic [paddr_width_gp-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch cache_req_o: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_way(logic [way_id_width_gp-1:0] got, logic [way_id_width_gp-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch repl_way_o: got 0x%h, expected 0x%h", got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // a tag that no way of the set holds
  function automatic logic [ptag_width_gp-1:0] fresh_tag(int idx);
    logic [31:0] rnd;
    logic clash;
    do begin
      rnd = lcg_next();
      clash = 1'b0;
      for (int w = 0; w < assoc_gp; w++) begin
        if (tag_m[idx][w] == rnd[31 -: ptag_width_gp]) begin
          clash = 1'b1;
        end
      end
    end while (clash);
    return rnd[31 -: ptag_width_gp];
  endfunction

  // bit 0 picks the pair, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3
  function automatic logic [lru_width_gp-1:0] touch_tree(logic [lru_width_gp-1:0] s, int way);
    logic [lru_width_gp-1:0] n;
    n = s;
    if (way < 2) begin
      n[0] = 1'b1;
      n[1] = (way == 0);
    end else begin
      n[0] = 1'b0;
      n[2] = (way == 2);
    end
    return n;
  endfunction

  function automatic logic [way_id_width_gp-1:0] tree_victim(logic [lru_width_gp-1:0] s);
    if (!s[0]) begin
      return s[1] ? 2'd1 : 2'd0;
    end
    return s[2] ? 2'd3 : 2'd2;
  endfunction

  function automatic void add_row(op_e op, int idx, int way, logic exp_hit);
    row_t r;
    r.op = op;
    r.idx = idx;
    r.way = way;
    r.exp_hit = exp_hit;
    stim_q.push_back(r);
  endfunction

  function automatic void build_table();
    for (int w = 0; w < assoc_gp; w++) begin
      add_row(op_tag, 5, w, 1'b0);
      add_row(op_block, 5, w, 1'b0);
    end
    for (int w = 0; w < assoc_gp; w++) begin
      add_row(op_sweep, 5, w, 1'b1);
    end
    // steer the tree before a miss to the full set
    add_row(op_acc, 5, 1, 1'b1);
    add_row(op_acc, 5, 2, 1'b1);
    add_row(op_acc, 5, 0, 1'b1);
    add_row(op_new, 5, 0, 1'b0);
    add_row(op_done, 5, 0, 1'b0);
    // half full set
    add_row(op_tag, 9, 0, 1'b0);
    add_row(op_tag, 9, 1, 1'b0);
    add_row(op_block, 9, 0, 1'b0);
    add_row(op_block, 9, 1, 1'b0);
    add_row(op_acc, 9, 1, 1'b1);
    add_row(op_new, 9, 0, 1'b0);
    add_row(op_done, 9, 0, 1'b0);
    // old tag of an invalidated way
    add_row(op_inval, 5, 2, 1'b0);
    add_row(op_acc, 5, 2, 1'b0);
    add_row(op_done, 5, 0, 1'b0);
    add_row(op_tag, 5, 2, 1'b0);
    add_row(op_block, 5, 2, 1'b0);
    add_row(op_sweep, 5, 2, 1'b1);
    add_row(op_new, 5, 0, 1'b0);
    add_row(op_done, 5, 0, 1'b0);
    add_row(op_clear, 9, 0, 1'b0);
    add_row(op_acc, 9, 0, 1'b0);
    add_row(op_done, 9, 0, 1'b0);
  endfunction

  task automatic fill_tag(tag_op_e op, int idx, int way, logic [ptag_width_gp-1:0] tag);
    @(posedge clk_i);
    tag_fill_v_i <= 1'b1;
    tag_fill_op_i <= op;
    tag_fill_index_i <= index_width_gp'(idx);
    tag_fill_way_i <= way_id_width_gp'(way);
    tag_fill_tag_i <= tag;
    @(negedge clk_i);
    for (int n = 0; !tag_fill_yumi_o; n++) begin
      if (n == strobe_wait_lp) begin
        fail_run("tag fill was never accepted by the cache");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    tag_fill_v_i <= 1'b0;
    for (int w = 0; w < assoc_gp; w++) begin
      if (op == set_clear || (op == invalidate && w == way)) begin
        valid_m[idx][w] = 1'b0;
      end
    end
    if (op == set_tag) begin
      valid_m[idx][way] = 1'b1;
      tag_m[idx][way] = tag;
    end
  endtask

  task automatic fill_block(int idx, int way);
    logic [block_width_gp-1:0] blk;
    for (int i = 0; i < block_width_gp / 32; i++) begin
      blk[i*32 +: 32] = lcg_next();
    end
    @(posedge clk_i);
    data_fill_v_i <= 1'b1;
    data_fill_index_i <= index_width_gp'(idx);
    data_fill_way_i <= way_id_width_gp'(way);
    data_fill_block_i <= blk;
    @(negedge clk_i);
    for (int n = 0; !data_fill_yumi_o; n++) begin
      if (n == strobe_wait_lp) begin
        fail_run("data fill was never accepted by the cache");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    data_fill_v_i <= 1'b0;
    block_m[idx][way] = blk;
  endtask

  task automatic issue_access(int idx, logic [ptag_width_gp-1:0] ptag, int word, int slot,
                              logic exp_hit);
    logic [31:0] rnd;
    logic [vaddr_width_gp-1:0] va;
    logic [instr_width_gp-1:0] exp_instr;
    logic [way_id_width_gp-1:0] exp_way;
    logic model_hit;
    logic found;
    int hw;
    rnd = lcg_next();
    va = {rnd[vaddr_width_gp-1:page_offset_width_gp], index_width_gp'(idx),
          word_offset_width_gp'(word), slot_width_lp'(slot), 2'b00};
    model_hit = 1'b0;
    hw = 0;
    for (int w = 0; w < assoc_gp; w++) begin
      if (valid_m[idx][w] && tag_m[idx][w] == ptag) begin
        model_hit = 1'b1;
        hw = w;
      end
    end
    if (model_hit != exp_hit) begin
      fail_run("stimulus table and reference model disagree on a hit");
    end
    @(posedge clk_i);
    vaddr_i <= va;
    vaddr_v_i <= 1'b1;
    @(negedge clk_i);
    for (int n = 0; !vaddr_ready_o; n++) begin
      if (n == strobe_wait_lp) begin
        fail_run("access was never accepted by the cache");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    vaddr_v_i <= 1'b0;
    ptag_i <= ptag;
    ptag_v_i <= 1'b1;
    @(posedge clk_i);
    ptag_v_i <= 1'b0;
    @(negedge clk_i);
    check_bit("instr_v_o", instr_v_o, exp_hit);
    check_bit("cache_req_v_o", cache_req_v_o, !exp_hit);
    // a request being raised also blocks new accesses
    check_bit("vaddr_ready_o", vaddr_ready_o, exp_hit);
    if (exp_hit) begin
      exp_instr = block_m[idx][hw][word*bank_width_gp + slot*instr_width_gp +: instr_width_gp];
      check_instr(instr_o, exp_instr);
      plru_m[idx] = touch_tree(plru_m[idx], hw);
    end else begin
      check_req_addr(cache_req_o, {ptag, va[page_offset_width_gp-1:0]});
      // an empty way wins over the tree
      exp_way = tree_victim(plru_m[idx]);
      found = 1'b0;
      for (int w = 0; w < assoc_gp; w++) begin
        if (!found && !valid_m[idx][w]) begin
          exp_way = way_id_width_gp'(w);
          found = 1'b1;
        end
      end
      @(negedge clk_i);
      check_bit("repl_way_v_o", repl_way_v_o, 1'b1);
      check_way(repl_way_o, exp_way);
      check_bit("miss_o", miss_o, 1'b1);
      check_bit("vaddr_ready_o", vaddr_ready_o, 1'b0);
      miss_pending = 1'b1;
    end
  endtask

  task automatic complete_miss();
    if (!miss_pending) begin
      fail_run("complete row given with no miss outstanding");
    end
    @(posedge clk_i);
    cache_req_complete_i <= 1'b1;
    @(negedge clk_i);
    check_bit("miss_o", miss_o, 1'b1);
    check_bit("vaddr_ready_o", vaddr_ready_o, 1'b0);
    @(posedge clk_i);
    cache_req_complete_i <= 1'b0;
    @(negedge clk_i);
    check_bit("miss_o", miss_o, 1'b0);
    check_bit("vaddr_ready_o", vaddr_ready_o, 1'b1);
    miss_pending = 1'b0;
  endtask

  task automatic run_row(row_t r);
    logic [ptag_width_gp-1:0] t;
    logic [31:0] rnd;
    case (r.op)
      op_clear: fill_tag(set_clear, r.idx, 0, '0);
      op_tag: begin
        t = fresh_tag(r.idx);
        fill_tag(set_tag, r.idx, r.way, t);
      end
      op_inval: fill_tag(invalidate, r.idx, r.way, '0);
      op_block: fill_block(r.idx, r.way);
      op_acc, op_new: begin
        if (r.op == op_acc) begin
          t = tag_m[r.idx][r.way];
        end else begin
          t = fresh_tag(r.idx);
        end
        rnd = lcg_next();
        issue_access(r.idx, t, int'(rnd[31:30]), int'(rnd[29:28]), r.exp_hit);
      end
      op_sweep: begin
        for (int w = 0; w < assoc_gp; w++) begin
          for (int s = 0; s < 4; s++) begin
            issue_access(r.idx, tag_m[r.idx][r.way], w, s, r.exp_hit);
          end
        end
      end
      op_done: complete_miss();
      default: fail_run("unknown operation in the stimulus table");
    endcase
  endtask

  initial begin
    lcg_state = 32'h15ab_7832;
    miss_pending = 1'b0;
    reset_i <= 1'b1;
    vaddr_i <= '0;
    vaddr_v_i <= 1'b0;
    ptag_i <= '0;
    ptag_v_i <= 1'b0;
    cache_req_ready_i <= 1'b1;
    cache_req_complete_i <= 1'b0;
    tag_fill_v_i <= 1'b0;
    tag_fill_op_i <= set_clear;
    tag_fill_index_i <= '0;
    tag_fill_way_i <= '0;
    tag_fill_tag_i <= '0;
    data_fill_v_i <= 1'b0;
    data_fill_index_i <= '0;
    data_fill_way_i <= '0;
    data_fill_block_i <= '0;
    for (int s = 0; s < sets_gp; s++) begin
      plru_m[s] = '0;
      for (int w = 0; w < assoc_gp; w++) begin
        valid_m[s][w] = 1'b0;
        tag_m[s][w] = '0;
      end
    end
    build_table();
    table_built = 1'b1;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int s = 0; s < sets_gp; s++) begin
      fill_tag(set_clear, s, 0, '0);
    end
    @(negedge clk_i);
    check_bit("instr_v_o", instr_v_o, 1'b0);
    check_bit("cache_req_v_o", cache_req_v_o, 1'b0);
    check_bit("repl_way_v_o", repl_way_v_o, 1'b0);
    check_bit("miss_o", miss_o, 1'b0);
    foreach (stim_q[i]) begin
      run_row(stim_q[i]);
    end
    $display("All tests passed");
    $finish;
  end

  // watchdog
  initial begin
    int steps;
    wait (table_built);
    steps = 0;
    // a sweep row makes one access per word and slot
    foreach (stim_q[i]) begin
      steps += (stim_q[i].op == op_sweep) ? 16 : 1;
    end
    repeat (16 + 4 * sets_gp + 20 * steps) @(posedge clk_i);
    fail_run("watchdog expired before the test sequence finished");
  end

endmodule

// File: src.f
common/icache_pkg.sv
src/tag_lookup.sv
src/data_banks.sv
src/lru_tracker.sv
src/tv_stage.sv
src/icache.sv
test/icache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module icache_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vicache_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
